/* logic/decode_settings.svh */
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// integer register and datapath width
`define XLEN 64

// fetched instruction width
`define ILEN 32

// register index, 32 architectural registers
`define REG_ADDR_W 5

`endif

/* logic/rvIsaPkg.sv */
`include "decode_settings.svh"

package rvIsaPkg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_BRANCH    = 7'b1100011,
    OPC_LOAD      = 7'b0000011,
    OPC_STORE     = 7'b0100011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_OP        = 7'b0110011,
    OPC_OP_32     = 7'b0111011
  } opcodeE;

  // immediate layout of the instruction
  // BAD marks an opcode outside the kept set
  typedef enum logic [2:0] {R, I, S, B, U, J, BAD} instFormatE;

  // operations understood by execute
  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } aluOpE;

  // one bit per byte lane of a doubleword
  typedef logic [`XLEN/8-1:0] storeMaskT;

endpackage

/* logic/decodeBusPkg.sv */
`include "decode_settings.svh"

package decodeBusPkg;

  // from fetch
  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  pc;
    logic [`ILEN-1:0]  inst;
  } fetchPacketT;

  // bypass network, pass[0] for rs1 and pass[1] for rs2
  typedef struct packed {
    logic [1:0]        pass;
    logic [`XLEN-1:0]  data;
  } bypassT;

  // opcode class, shared by the decode pieces
  typedef struct packed {
    rvIsaPkg::instFormatE format;
    logic loadEn;
    logic storeEn;
    logic writeEn;
    logic wordOp;
    logic isBranch;
    logic isJal;
    logic isJalr;
    logic isLui;
    logic isAuipc;
    logic illegal;
  } ctrlFlagsT;

  // pc redirect, target is zero when not taken
  typedef struct packed {
    logic              taken;
    logic [`XLEN-1:0]  target;
  } redirectT;

  // toward execute
  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    rvIsaPkg::aluOpE        aluOp;
    logic [`XLEN-1:0]       opA;
    logic [`XLEN-1:0]       opB;
    logic [`XLEN-1:0]       storeData;
    logic [`XLEN-1:0]       imm;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   writeEn;
    logic                   loadEn;
    logic                   storeEn;
    rvIsaPkg::storeMaskT    storeMask;
    // load width and sign for the LSU
    logic [2:0]             funct3;
    logic                   wordOp;
    logic                   illegal;
    redirectT               redirect;
  } execPacketT;

endpackage

/* logic/instClassifier.sv */
`include "decode_settings.svh"

module instClassifier (
  input  logic [`ILEN-1:0]       inst,
  output decodeBusPkg::ctrlFlagsT flags
);

  always_comb begin
    flags = '0;
    // unknown opcode unless matched below
    flags.format = rvIsaPkg::BAD;
    case (inst[6:0])
      rvIsaPkg::OPC_LUI: begin
        flags.format = rvIsaPkg::U;
        flags.isLui  = 1'b1;
      end
      rvIsaPkg::OPC_AUIPC: begin
        flags.format  = rvIsaPkg::U;
        flags.isAuipc = 1'b1;
      end
      rvIsaPkg::OPC_JAL: begin
        flags.format = rvIsaPkg::J;
        flags.isJal  = 1'b1;
      end
      // jalr uses the I layout
      rvIsaPkg::OPC_JALR: begin
        flags.format = rvIsaPkg::I;
        flags.isJalr = 1'b1;
      end
      rvIsaPkg::OPC_BRANCH: begin
        flags.format   = rvIsaPkg::B;
        flags.isBranch = 1'b1;
      end
      rvIsaPkg::OPC_LOAD: begin
        flags.format = rvIsaPkg::I;
        flags.loadEn = 1'b1;
      end
      rvIsaPkg::OPC_STORE: begin
        flags.format  = rvIsaPkg::S;
        flags.storeEn = 1'b1;
      end
      rvIsaPkg::OPC_OP_IMM: flags.format = rvIsaPkg::I;
      // word variants, result sign-extended from bit 31 in execute
      rvIsaPkg::OPC_OP_IMM_32: begin
        flags.format = rvIsaPkg::I;
        flags.wordOp = 1'b1;
      end
      rvIsaPkg::OPC_OP: flags.format = rvIsaPkg::R;
      rvIsaPkg::OPC_OP_32: begin
        flags.format = rvIsaPkg::R;
        flags.wordOp = 1'b1;
      end
      default: flags.format = rvIsaPkg::BAD;
    endcase
    // stores, branches and bad opcodes write no rd
    flags.writeEn = !(flags.format inside {rvIsaPkg::S, rvIsaPkg::B, rvIsaPkg::BAD});
    flags.illegal = (flags.format == rvIsaPkg::BAD);
  end

endmodule

/* logic/immediateGen.sv */
`include "decode_settings.svh"

module immediateGen (
  input  logic [`ILEN-1:0]   inst,
  input  rvIsaPkg::instFormatE format,
  output logic [`XLEN-1:0]   imm
);

  // all formats sign-extend from inst[31]
  always_comb begin
    case (format)
      rvIsaPkg::I: imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
      rvIsaPkg::S: imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
      // branch offset, bit 0 implied zero
      rvIsaPkg::B: imm = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      // upper 20 bits, low 12 zero
      rvIsaPkg::U: imm = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
      rvIsaPkg::J: begin
        imm = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      // R and BAD carry no immediate
      default: imm = '0;
    endcase
  end

endmodule

/* logic/aluOpDecoder.sv */
`include "decode_settings.svh"

module aluOpDecoder (
  input  logic [`ILEN-1:0] inst,
  output rvIsaPkg::aluOpE  aluOp
);

  logic [2:0] funct3;
  logic       bit30;
  logic       regForm;
  logic       immForm;

  assign funct3 = inst[14:12];
  // funct7[5], picks sub and arithmetic shift
  assign bit30  = inst[30];

  // register-register forms, 64 and 32 bit
  assign regForm = (inst[6:0] == rvIsaPkg::OPC_OP) || (inst[6:0] == rvIsaPkg::OPC_OP_32);
  // register-immediate forms
  assign immForm = (inst[6:0] == rvIsaPkg::OPC_OP_IMM)
                || (inst[6:0] == rvIsaPkg::OPC_OP_IMM_32);

  always_comb begin
    aluOp = rvIsaPkg::ADD;
    if (regForm || immForm) begin
      case (funct3)
        // no subi, bit 30 is imm there
        3'b000: aluOp = (regForm && bit30) ? rvIsaPkg::SUB : rvIsaPkg::ADD;
        3'b001: aluOp = rvIsaPkg::SLL;
        3'b010: aluOp = rvIsaPkg::SLT;
        3'b011: aluOp = rvIsaPkg::SLTU;
        3'b100: aluOp = rvIsaPkg::XOR;
        // shifts keep bit 30 clear of shamt
        3'b101: aluOp = bit30 ? rvIsaPkg::SRA : rvIsaPkg::SRL;
        3'b110: aluOp = rvIsaPkg::OR;
        3'b111: aluOp = rvIsaPkg::AND;
        default: aluOp = rvIsaPkg::ADD;
      endcase
    end
    // loads, stores, jumps, lui, auipc all add
  end

endmodule

/* logic/operandSelect.sv */
`include "decode_settings.svh"

module operandSelect (
  input  logic [`ILEN-1:0]         inst,
  input  logic [`XLEN-1:0]         pc,
  input  decodeBusPkg::ctrlFlagsT  flags,
  input  logic [`XLEN-1:0]         imm,
  input  logic [`XLEN-1:0]         rs1Data,
  input  logic [`XLEN-1:0]         rs2Data,
  input  logic                     busy1,
  input  logic                     busy2,
  input  decodeBusPkg::bypassT     bypass,
  output logic [`XLEN-1:0]         rs1Val,
  output logic [`XLEN-1:0]         rs2Val,
  output logic [`XLEN-1:0]         opA,
  output logic [`XLEN-1:0]         opB,
  output logic                     hazard
);

  logic isShift;
  logic isRightShift;

  // bypass only for a busy source, x0 writes must not leak through
  assign rs1Val = (busy1 && bypass.pass[0]) ? bypass.data : rs1Data;
  assign rs2Val = (busy2 && bypass.pass[1]) ? bypass.data : rs2Data;

  // producer still in flight and not yet on the bypass
  assign hazard = (busy1 && !bypass.pass[0]) || (busy2 && !bypass.pass[1]);

  // sll, srl, sra and their immediate forms
  assign isShift      = (inst[13:12] == 2'b01);
  assign isRightShift = (inst[14:12] == 3'b101);

  always_comb begin
    opA = '0;
    opB = '0;
    if (flags.illegal || flags.isBranch) begin
      // branches are resolved here, execute gets zeros
      opA = '0;
    end else if (flags.isJal || flags.isJalr) begin
      // link value pc + 4
      opA = pc;
      opB = `XLEN'd4;
    end else if (flags.isLui) begin
      opB = imm;
    end else if (flags.isAuipc) begin
      opA = pc;
      opB = imm;
    end else if (flags.loadEn || flags.storeEn) begin
      // effective address
      opA = rs1Val;
      opB = imm;
    end else begin
      opA = rs1Val;
      // word right shifts see only the low word, sign per bit 30
      if (flags.wordOp && isRightShift) begin
        opA = inst[30] ? {{(`XLEN-32){rs1Val[31]}}, rs1Val[31:0]}
                       : {{(`XLEN-32){1'b0}}, rs1Val[31:0]};
      end
      if (flags.format == rvIsaPkg::R) begin
        if (!isShift) opB = rs2Val;
        else if (flags.wordOp) opB = {{(`XLEN-5){1'b0}}, rs2Val[4:0]};
        else opB = {{(`XLEN-6){1'b0}}, rs2Val[5:0]};
      end else begin
        // shamt drops the funct6 bits of the immediate
        opB = isShift ? {{(`XLEN-6){1'b0}}, inst[25:20]} : imm;
      end
    end
  end

endmodule

/* logic/branchResolve.sv */
`include "decode_settings.svh"

module branchResolve (
  input  logic [`ILEN-1:0]        inst,
  input  logic [`XLEN-1:0]        pc,
  input  decodeBusPkg::ctrlFlagsT flags,
  input  logic [`XLEN-1:0]        imm,
  input  logic [`XLEN-1:0]        rs1Val,
  input  logic [`XLEN-1:0]        rs2Val,
  output decodeBusPkg::redirectT  redirect
);

  logic             cond;
  logic [`XLEN-1:0] jumpTarget;

  // branch condition from funct3
  always_comb begin
    case (inst[14:12])
      3'b000: cond = (rs1Val == rs2Val);
      3'b001: cond = (rs1Val != rs2Val);
      3'b100: cond = ($signed(rs1Val) < $signed(rs2Val));
      3'b101: cond = ($signed(rs1Val) >= $signed(rs2Val));
      3'b110: cond = (rs1Val < rs2Val);
      3'b111: cond = (rs1Val >= rs2Val);
      // 010 and 011 are not branches
      default: cond = 1'b0;
    endcase
  end

  // jalr is register relative with bit 0 cleared
  assign jumpTarget = flags.isJalr ? ((rs1Val + imm) & ~`XLEN'd1) : (pc + imm);

  assign redirect.taken  = flags.isJal || flags.isJalr || (flags.isBranch && cond);
  // zero target keeps not-taken packets clean
  assign redirect.target = redirect.taken ? jumpTarget : '0;

endmodule

/* logic/idExRegister.sv */
`include "decode_settings.svh"

module idExRegister (
  input  logic                     clock,
  input  logic                     arstN,
  input  logic                     loadValid,
  input  decodeBusPkg::execPacketT loadData,
  output logic                     loadReady,
  output logic                     execValid,
  input  logic                     execReady,
  output decodeBusPkg::execPacketT exec
);

  decodeBusPkg::execPacketT payloadQ;
  logic                     takenQ;

  // empty, or the held item leaves this cycle
  assign loadReady = !execValid || execReady;

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      execValid <= 1'b0;
      takenQ    <= 1'b0;
    end else if (loadReady) begin
      execValid <= loadValid;
      // redirect only with a live packet
      takenQ    <= loadValid && loadData.redirect.taken;
    end
  end

  // payload only moves on an actual load
  always_ff @(posedge clock) begin
    if (loadValid && loadReady) begin
      payloadQ <= loadData;
    end
  end

  always_comb begin
    exec                = payloadQ;
    exec.redirect.taken = takenQ;
  end

endmodule

/* logic/decodeStage.sv */
`include "decode_settings.svh"

module decodeStage (
  input  logic                      clock,
  input  logic                      arstN,
  input  decodeBusPkg::fetchPacketT fetch,
  output logic                      fetchReady,
  output logic [`REG_ADDR_W-1:0]    rs1Addr,
  output logic [`REG_ADDR_W-1:0]    rs2Addr,
  input  logic [`XLEN-1:0]          rs1Data,
  input  logic [`XLEN-1:0]          rs2Data,
  input  logic                      busy1,
  input  logic                      busy2,
  input  decodeBusPkg::bypassT      bypass,
  output decodeBusPkg::execPacketT  exec,
  output logic                      execValid,
  input  logic                      execReady
);

  decodeBusPkg::ctrlFlagsT  flags;
  decodeBusPkg::redirectT   redirect;
  decodeBusPkg::execPacketT packet;
  rvIsaPkg::aluOpE          aluOp;
  rvIsaPkg::storeMaskT      storeMask;
  logic [`XLEN-1:0]         imm;
  logic [`XLEN-1:0]         rs1Val;
  logic [`XLEN-1:0]         rs2Val;
  logic [`XLEN-1:0]         opA;
  logic [`XLEN-1:0]         opB;
  logic                     hazard;
  logic                     loadReady;

  // register file read ports, combinational return
  assign rs1Addr = fetch.inst[19:15];
  assign rs2Addr = fetch.inst[24:20];

  instClassifier uClassifier (.inst(fetch.inst), .flags(flags));

  immediateGen uImmGen (.inst(fetch.inst), .format(flags.format), .imm(imm));

  aluOpDecoder uAluOp (.inst(fetch.inst), .aluOp(aluOp));

  operandSelect uOperands (
    .inst(fetch.inst), .pc(fetch.pc), .flags(flags), .imm(imm),
    .rs1Data(rs1Data), .rs2Data(rs2Data), .busy1(busy1), .busy2(busy2),
    .bypass(bypass), .rs1Val(rs1Val), .rs2Val(rs2Val), .opA(opA), .opB(opB),
    .hazard(hazard)
  );

  branchResolve uBranch (
    .inst(fetch.inst), .pc(fetch.pc), .flags(flags), .imm(imm),
    .rs1Val(rs1Val), .rs2Val(rs2Val), .redirect(redirect)
  );

  // sb, sh, sw, sd lanes from the low end
  always_comb begin
    storeMask = '0;
    if (flags.storeEn) begin
      case (fetch.inst[14:12])
        3'b000: storeMask = 8'h01;
        3'b001: storeMask = 8'h03;
        3'b010: storeMask = 8'h0F;
        3'b011: storeMask = 8'hFF;
        default: storeMask = '0;
      endcase
    end
  end

  always_comb begin
    packet.pc        = fetch.pc;
    packet.aluOp     = aluOp;
    packet.opA       = opA;
    packet.opB       = opB;
    // store data is the forwarded rs2
    packet.storeData = rs2Val;
    packet.imm       = imm;
    packet.rd        = fetch.inst[11:7];
    packet.writeEn   = flags.writeEn;
    packet.loadEn    = flags.loadEn;
    packet.storeEn   = flags.storeEn;
    packet.storeMask = storeMask;
    packet.funct3    = fetch.inst[14:12];
    packet.wordOp    = flags.wordOp;
    packet.illegal   = flags.illegal;
    packet.redirect  = redirect;
  end

  // stall on a scoreboard hazard or a full output register
  assign fetchReady = !hazard && loadReady;

  idExRegister uIdEx (
    .clock(clock), .arstN(arstN),
    .loadValid(fetch.valid && !hazard), .loadData(packet), .loadReady(loadReady),
    .execValid(execValid), .execReady(execReady), .exec(exec)
  );

endmodule

/* tb/decodeStage_checker.sv */
module decodeStage_checker (
  input logic                     clock,
  input logic                     arstN,
  input logic                     execValid,
  input logic                     execReady,
  input decodeBusPkg::execPacketT exec
);

  timeunit 1ns;
  timeprecision 100ps;

  // stalled packet must not move or vanish
  holdStable: assert property (
    @(posedge clock) disable iff (!arstN)
    execValid && !execReady |=> execValid && $stable(exec)
  ) else $error("exec packet changed while stalled");

  // output register empty during reset
  resetEmpty: assert property (
    @(posedge clock) !arstN |-> !execValid
  ) else $error("execValid high during reset");

  // redirect only rides on a live packet
  takenNeedsValid: assert property (
    @(posedge clock) exec.redirect.taken |-> execValid
  ) else $error("redirect taken without execValid");

endmodule

bind idExRegister decodeStage_checker uChecker (
  .clock(clock), .arstN(arstN), .execValid(execValid),
  .execReady(execReady), .exec(exec)
);

/* tb/decodeStage_tb.sv */
`include "decode_settings.svh"

module decodeStage_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_INST = 600;
  // 600 instructions at up to 4 cycles each, plus drain and reset
  localparam int MAX_CYCLES = NUM_INST * 4 + 600;

  logic                      clock = 1'b0;
  logic                      arstN;
  decodeBusPkg::fetchPacketT fetch;
  logic                      fetchReady;
  logic [`REG_ADDR_W-1:0]    rs1Addr;
  logic [`REG_ADDR_W-1:0]    rs2Addr;
  logic [`XLEN-1:0]          rs1Data;
  logic [`XLEN-1:0]          rs2Data;
  logic                      busy1;
  logic                      busy2;
  decodeBusPkg::bypassT      bypass;
  decodeBusPkg::execPacketT  exec;
  logic                      execValid;
  logic                      execReady;

  logic [`XLEN-1:0]          regs [32];
  decodeBusPkg::execPacketT  expQ [$];
  int                        cycles = 0;

  always #2 clock = ~clock;

  // register file model, combinational read
  assign rs1Data = regs[rs1Addr];
  assign rs2Data = regs[rs2Addr];

  decodeStage DUT (
    .clock(clock), .arstN(arstN), .fetch(fetch), .fetchReady(fetchReady),
    .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rs1Data(rs1Data), .rs2Data(rs2Data),
    .busy1(busy1), .busy2(busy2), .bypass(bypass),
    .exec(exec), .execValid(execValid), .execReady(execReady)
  );

  task automatic checkValue(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic [63:0] forwardValue(logic busy, logic pass, logic [63:0] regVal,
                                               logic [63:0] data);
    return (busy && pass) ? data : regVal;
  endfunction

  function automatic rvIsaPkg::aluOpE aluFor(logic [2:0] f3, logic bit30, logic regForm);
    case (f3)
      3'd0: return (regForm && bit30) ? rvIsaPkg::SUB : rvIsaPkg::ADD;
      3'd1: return rvIsaPkg::SLL;
      3'd2: return rvIsaPkg::SLT;
      3'd3: return rvIsaPkg::SLTU;
      3'd4: return rvIsaPkg::XOR;
      3'd5: return bit30 ? rvIsaPkg::SRA : rvIsaPkg::SRL;
      3'd6: return rvIsaPkg::OR;
      default: return rvIsaPkg::AND;
    endcase
  endfunction

  // expected execute packet straight from the ISA rules
  function automatic decodeBusPkg::execPacketT expectPacket(logic [31:0] inst,
      logic [63:0] pc, logic [63:0] a, logic [63:0] b);
    decodeBusPkg::execPacketT p;
    logic [2:0]  f3;
    logic [63:0] iImm;
    logic [63:0] sImm;
    logic [63:0] bImm;
    logic [63:0] uImm;
    logic [63:0] jImm;
    logic        shift;
    logic        word;
    logic        cond;
    f3    = inst[14:12];
    iImm  = {{52{inst[31]}}, inst[31:20]};
    sImm  = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    bImm  = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    uImm  = {{32{inst[31]}}, inst[31:12], 12'b0};
    jImm  = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    shift = (f3 == 3'd1) || (f3 == 3'd5);
    word  = (inst[6:0] == 7'b0111011) || (inst[6:0] == 7'b0011011);
    p = '0;
    p.pc        = pc;
    p.rd        = inst[11:7];
    p.funct3    = f3;
    p.storeData = b;
    p.aluOp     = rvIsaPkg::ADD;
    case (inst[6:0])
      7'b0110111: begin
        p.imm = uImm;
        p.opB = uImm;
        p.writeEn = 1'b1;
      end
      7'b0010111: begin
        p.imm = uImm;
        p.opA = pc;
        p.opB = uImm;
        p.writeEn = 1'b1;
      end
      7'b1101111: begin
        p.imm = jImm;
        p.opA = pc;
        p.opB = 64'd4;
        p.writeEn = 1'b1;
        p.redirect.taken  = 1'b1;
        p.redirect.target = pc + jImm;
      end
      7'b1100111: begin
        p.imm = iImm;
        p.opA = pc;
        p.opB = 64'd4;
        p.writeEn = 1'b1;
        p.redirect.taken  = 1'b1;
        p.redirect.target = (a + iImm) & ~64'd1;
      end
      7'b1100011: begin
        p.imm = bImm;
        case (f3)
          3'd0: cond = (a == b);
          3'd1: cond = (a != b);
          3'd4: cond = ($signed(a) < $signed(b));
          3'd5: cond = ($signed(a) >= $signed(b));
          3'd6: cond = (a < b);
          3'd7: cond = (a >= b);
          default: cond = 1'b0;
        endcase
        p.redirect.taken  = cond;
        p.redirect.target = cond ? pc + bImm : 64'd0;
      end
      7'b0000011: begin
        p.imm = iImm;
        p.opA = a;
        p.opB = iImm;
        p.loadEn = 1'b1;
        p.writeEn = 1'b1;
      end
      7'b0100011: begin
        p.imm = sImm;
        p.opA = a;
        p.opB = sImm;
        p.storeEn = 1'b1;
        case (f3)
          3'd0: p.storeMask = 8'h01;
          3'd1: p.storeMask = 8'h03;
          3'd2: p.storeMask = 8'h0F;
          3'd3: p.storeMask = 8'hFF;
          default: p.storeMask = 8'h00;
        endcase
      end
      7'b0110011, 7'b0111011, 7'b0010011, 7'b0011011: begin
        p.writeEn = 1'b1;
        p.wordOp  = word;
        p.opA     = a;
        // word right shifts look at the low word only
        if (word && f3 == 3'd5) begin
          p.opA = inst[30] ? {{32{a[31]}}, a[31:0]} : {32'd0, a[31:0]};
        end
        if (inst[5]) begin
          p.aluOp = aluFor(f3, inst[30], 1'b1);
          if (!shift) p.opB = b;
          else if (word) p.opB = {59'd0, b[4:0]};
          else p.opB = {58'd0, b[5:0]};
        end else begin
          p.imm   = iImm;
          p.aluOp = aluFor(f3, inst[30], 1'b0);
          p.opB   = shift ? {58'd0, inst[25:20]} : iImm;
        end
      end
      default: p.illegal = 1'b1;
    endcase
    return p;
  endfunction

  function automatic logic [2:0] wordFunct3();
    case ($urandom % 3)
      0: return 3'd0;
      1: return 3'd1;
      default: return 3'd5;
    endcase
  endfunction

  // legal encodings of the kept classes, plus a few foreign opcodes
  function automatic logic [31:0] makeInst();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm12;
    logic [6:0]  f7;
    int unsigned kind;
    int unsigned pick;
    rd    = 5'($urandom);
    rs1   = 5'($urandom);
    // same source sometimes, for equal branch operands
    rs2   = ($urandom % 4 == 0) ? rs1 : 5'($urandom);
    f3    = 3'($urandom);
    imm12 = 12'($urandom);
    f7    = 7'h00;
    kind  = $urandom % 12;
    case (kind)
      0, 1: begin
        if (kind == 1) f3 = wordFunct3();
        if ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 0)) f7 = 7'h20;
        return {f7, rs2, rs1, f3, rd, (kind == 0) ? 7'b0110011 : 7'b0111011};
      end
      2, 3: begin
        if (kind == 3) f3 = wordFunct3();
        if (f3 == 3'd1 || f3 == 3'd5) begin
          f7 = (f3 == 3'd5 && ($urandom % 2 == 0)) ? 7'h20 : 7'h00;
          imm12 = {f7[6:1], (kind == 3) ? 1'b0 : imm12[5], imm12[4:0]};
        end
        return {imm12, rs1, f3, rd, (kind == 2) ? 7'b0010011 : 7'b0011011};
      end
      4: return {imm12, rs1, 3'($urandom % 7), rd, 7'b0000011};
      5: return {imm12[11:5], rs2, rs1, 3'($urandom % 4), imm12[4:0], 7'b0100011};
      6: return {20'($urandom), rd, 7'b0110111};
      7: return {20'($urandom), rd, 7'b0010111};
      8: begin
        pick = $urandom % 6;
        f3 = (pick < 2) ? 3'(pick) : 3'(pick + 2);
        return {7'($urandom), rs2, rs1, f3, 5'($urandom), 7'b1100011};
      end
      9: return {20'($urandom), rd, 7'b1101111};
      10: return {imm12, rs1, 3'd0, rd, 7'b1100111};
      default: begin
        // system, fence, amo and an unused code
        case ($urandom % 4)
          0: return {25'($urandom), 7'b1110011};
          1: return {25'($urandom), 7'b0001111};
          2: return {25'($urandom), 7'b0101111};
          default: return {25'($urandom), 7'b1111111};
        endcase
      end
    endcase
  endfunction

  task automatic compareAll(decodeBusPkg::execPacketT got, decodeBusPkg::execPacketT exp);
    checkValue("exec.pc", got.pc, exp.pc);
    checkValue("exec.aluOp", 64'(got.aluOp), 64'(exp.aluOp));
    checkValue("exec.opA", got.opA, exp.opA);
    checkValue("exec.opB", got.opB, exp.opB);
    checkValue("exec.storeData", got.storeData, exp.storeData);
    checkValue("exec.imm", got.imm, exp.imm);
    checkValue("exec.rd", 64'(got.rd), 64'(exp.rd));
    checkValue("exec.writeEn", 64'(got.writeEn), 64'(exp.writeEn));
    checkValue("exec.loadEn", 64'(got.loadEn), 64'(exp.loadEn));
    checkValue("exec.storeEn", 64'(got.storeEn), 64'(exp.storeEn));
    checkValue("exec.storeMask", 64'(got.storeMask), 64'(exp.storeMask));
    checkValue("exec.funct3", 64'(got.funct3), 64'(exp.funct3));
    checkValue("exec.wordOp", 64'(got.wordOp), 64'(exp.wordOp));
    checkValue("exec.illegal", 64'(got.illegal), 64'(exp.illegal));
    checkValue("exec.redirect.taken", 64'(got.redirect.taken), 64'(exp.redirect.taken));
    checkValue("exec.redirect.target", got.redirect.target, exp.redirect.target);
  endtask

  // mid-cycle sampling, inputs settled since 1 ns after the edge
  always @(negedge clock) begin : compare
    decodeBusPkg::execPacketT exp;
    logic [63:0] a;
    logic [63:0] b;
    if (arstN) begin
      if ((busy1 && !bypass.pass[0]) || (busy2 && !bypass.pass[1])) begin
        checkValue("fetchReady", 64'(fetchReady), 64'd0);
      end
      if (execValid && execReady) begin
        if (expQ.size() == 0) begin
          $display("execute received a packet that was never accepted");
          $display("SIMULATION FAILED");
          $fatal(1);
        end
        exp = expQ.pop_front();
        compareAll(exec, exp);
      end
      if (fetch.valid && fetchReady) begin
        a = forwardValue(busy1, bypass.pass[0], regs[fetch.inst[19:15]], bypass.data);
        b = forwardValue(busy2, bypass.pass[1], regs[fetch.inst[24:20]], bypass.data);
        expQ.push_back(expectPacket(fetch.inst, fetch.pc, a, b));
      end
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d packets pending", cycles, expQ.size());
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  // execute back-pressure, mostly ready with short low bursts
  initial begin : backPressure
    int lowLeft;
    lowLeft = 0;
    execReady = 1'b0;
    @(negedge arstN);
    @(posedge arstN);
    forever begin
      @(posedge clock);
      #1;
      if (lowLeft > 0) begin
        execReady = 1'b0;
        lowLeft--;
      end else if ($urandom % 10 == 0) begin
        execReady = 1'b0;
        lowLeft = $urandom % 5;
      end else begin
        execReady = 1'b1;
      end
    end
  end

  initial begin : stimulus
    int  stallCycles;
    logic accepted;
    void'($urandom(36));
    fetch  = '0;
    busy1  = 1'b0;
    busy2  = 1'b0;
    bypass = '0;
    arstN  = 1'b1;
    // boundary values for branch compares, the rest random
    regs[0] = 64'd0;
    regs[1] = 64'h8000_0000_0000_0000;
    regs[2] = 64'h7FFF_FFFF_FFFF_FFFF;
    regs[3] = 64'hFFFF_FFFF_FFFF_FFFF;
    regs[4] = 64'h0000_0000_8000_0000;
    for (int r = 5; r < 32; r++) regs[r] = {$urandom, $urandom};
    #1 arstN = 1'b0;
    repeat (2) @(posedge clock);
    #1 arstN = 1'b1;
    for (int n = 0; n < NUM_INST; n++) begin
      if ($urandom % 8 == 0) begin
        fetch.valid = 1'b0;
        @(posedge clock);
        #1;
      end
      fetch.valid = 1'b1;
      fetch.pc    = {$urandom, $urandom} & ~64'd3;
      fetch.inst  = makeInst();
      busy1       = ($urandom % 4 == 0);
      busy2       = ($urandom % 4 == 0);
      bypass.pass = 2'b11;
      bypass.data = {$urandom, $urandom};
      // occasional producer not yet on the bypass
      stallCycles = ($urandom % 6 == 0) ? 1 + $urandom % 3 : 0;
      if (stallCycles > 0) begin
        busy1 = 1'b1;
        bypass.pass[0] = 1'b0;
      end
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clock);
        accepted = fetch.valid && fetchReady;
        @(posedge clock);
        #1;
        if (stallCycles > 0) begin
          stallCycles--;
          if (stallCycles == 0) bypass.pass = 2'b11;
        end
      end
    end
    fetch.valid = 1'b0;
    busy1 = 1'b0;
    busy2 = 1'b0;
    // drain the output register, every accepted packet must be gone
    while (execValid) @(negedge clock);
    if (expQ.size() == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("%0d accepted packets never reached execute", expQ.size());
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

endmodule

/* decodeStage.f */
+incdir+logic
logic/rvIsaPkg.sv
logic/decodeBusPkg.sv
logic/instClassifier.sv
logic/immediateGen.sv
logic/aluOpDecoder.sv
logic/operandSelect.sv
logic/branchResolve.sv
logic/idExRegister.sv
logic/decodeStage.sv
tb/decodeStage_checker.sv
tb/decodeStage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := decodeStage_tb
FILELIST  := decodeStage.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
